//--- rename_pkg.sv
package rename_pkg;

    localparam int TAG_W     = 7;  // Up to 128 physical registers.
    localparam int ARCH_REGS = 32;

    typedef logic [TAG_W-1:0] phys_tag_t;
    typedef logic [4:0]       arch_reg_t;

    // RV32I major opcodes, inst[6:0].
    typedef enum logic [6:0] {
        op_lui   = 7'b0110111,
        op_auipc = 7'b0010111,
        op_jal   = 7'b1101111,
        op_jalr  = 7'b1100111,
        op_br    = 7'b1100011,
        op_load  = 7'b0000011,
        op_store = 7'b0100011,
        op_imm   = 7'b0010011,
        op_reg   = 7'b0110011
    } opcode_t;

    typedef struct packed {
        opcode_t   opcode;
        arch_reg_t rd;
        arch_reg_t rs1;
        arch_reg_t rs2;
    } rename_req_t;

    typedef struct packed {
        phys_tag_t ps1;
        logic      ps1_valid;  // Source value already written back.
        phys_tag_t ps2;
        logic      ps2_valid;
        phys_tag_t pd;
        phys_tag_t pd_old;     // Freed when this instruction commits.
        logic      rd_we;
    } rename_rsp_t;

    typedef struct packed {
        logic      valid;
        phys_tag_t pd;
    } cdb_t;

    typedef struct packed {
        logic      valid;
        arch_reg_t rd;
        phys_tag_t pd;
        phys_tag_t pd_old;
    } commit_t;

endpackage

//--- rat.sv
module rat #(
    parameter int PHYS_REGS = 64,
    parameter int NUM_CDB   = 4
) (
    input  logic                                          clk,
    input  logic                                          rst,
    input  rename_pkg::rename_req_t                       req_data,
    input  logic                                          alloc,
    input  rename_pkg::phys_tag_t                         pd,
    input  rename_pkg::cdb_t [NUM_CDB-1:0]                cdb,
    input  logic                                          flush,
    input  rename_pkg::phys_tag_t [rename_pkg::ARCH_REGS-1:0] rrat_map,
    output rename_pkg::rename_rsp_t                       lookup
);
    import rename_pkg::*;

    phys_tag_t [ARCH_REGS-1:0] map_q;
    phys_tag_t [ARCH_REGS-1:0] map_d;
    logic      [ARCH_REGS-1:0] rdy_q;
    logic      [ARCH_REGS-1:0] rdy_d;
    logic                      reads_rs1;
    logic                      reads_rs2;

    assign reads_rs1 = !(req_data.opcode inside {op_lui, op_auipc, op_jal});
    assign reads_rs2 = !(req_data.opcode inside {op_lui, op_auipc, op_jal,
                                                 op_jalr, op_load, op_imm});

    // Lookup sees the table before this cycle's update.
    always_comb begin
        lookup           = '0;
        lookup.ps1       = reads_rs1 ? map_q[req_data.rs1] : '0;
        lookup.ps1_valid = reads_rs1 ? rdy_q[req_data.rs1] : 1'b1;
        lookup.ps2       = reads_rs2 ? map_q[req_data.rs2] : '0;
        lookup.ps2_valid = reads_rs2 ? rdy_q[req_data.rs2] : 1'b1;
        lookup.pd_old    = map_q[req_data.rd];
    end

    always_comb begin
        map_d = map_q;
        rdy_d = rdy_q;
        // Wake only entries whose current tag matches.
        for (int i = 0; i < ARCH_REGS; i++) begin
            for (int k = 0; k < NUM_CDB; k++) begin
                if (cdb[k].valid && cdb[k].pd == map_q[i]) begin
                    rdy_d[i] = 1'b1;
                end
            end
        end
        if (alloc && req_data.rd != '0) begin
            map_d[req_data.rd] = pd;
            rdy_d[req_data.rd] = 1'b0;  // Overrides a same-cycle wakeup of the old tag.
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < ARCH_REGS; i++) begin
                map_q[i] <= phys_tag_t'(i);
            end
            rdy_q <= '1;
        end else if (flush) begin
            map_q <= rrat_map;
            rdy_q <= '1;  // Committed values are all in the register file.
        end else begin
            map_q <= map_d;
            rdy_q <= rdy_d;
        end
    end

    // x0 stays pinned through allocation and flush.
    a_x0_fixed: assert property (@(posedge clk) disable iff (rst)
        map_q[0] == '0 && rdy_q[0]);

    // Tag 0 belongs to x0 and is never handed out.
    a_alloc_range: assert property (@(posedge clk) disable iff (rst)
        alloc |-> pd != '0 && int'(pd) < PHYS_REGS);

endmodule

//--- free_list.sv
module free_list #(
    parameter int PHYS_REGS = 64
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  alloc,
    input  rename_pkg::commit_t   commit,
    input  logic                  flush,
    output rename_pkg::phys_tag_t free_tag,
    output logic                  empty
);
    import rename_pkg::*;

    localparam int DEPTH = PHYS_REGS - ARCH_REGS;
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    phys_tag_t        mem [DEPTH];
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] shadow_ptr;  // Read pointer as of the last commit.
    logic [PTR_W-1:0] shadow_next;
    logic [CNT_W-1:0] count;
    logic             push;
    logic             full;

    function automatic logic [PTR_W-1:0] wrap_inc(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign push        = commit.valid && (commit.rd != '0);
    assign full        = (count == CNT_W'(DEPTH));
    assign empty       = (count == '0);
    assign free_tag    = mem[rd_ptr];
    assign shadow_next = push ? wrap_inc(shadow_ptr) : shadow_ptr;

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_ptr     <= '0;
            wr_ptr     <= '0;
            shadow_ptr <= '0;
            count      <= CNT_W'(DEPTH);
        end else begin
            shadow_ptr <= shadow_next;
            if (push) begin
                wr_ptr <= wrap_inc(wr_ptr);
            end
            if (flush) begin
                rd_ptr <= shadow_next;
                count  <= CNT_W'(DEPTH);  // Only the committed map holds tags now.
            end else begin
                if (alloc) begin
                    rd_ptr <= wrap_inc(rd_ptr);
                end
                count <= count + CNT_W'(push) - CNT_W'(alloc);
            end
        end
    end

    // Tags 32 and up start out free, in order.
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < DEPTH; i++) begin
                mem[i] <= phys_tag_t'(ARCH_REGS + i);
            end
        end else if (push) begin
            mem[wr_ptr] <= commit.pd_old;
        end
    end

    a_no_pop_empty: assert property (@(posedge clk) disable iff (rst) alloc |-> !empty);
    a_no_push_full: assert property (@(posedge clk) disable iff (rst) push |-> !full);

endmodule

//--- rrat.sv
module rrat #(
    parameter int PHYS_REGS = 64
) (
    input  logic                                              clk,
    input  logic                                              rst,
    input  rename_pkg::commit_t                               commit,
    output rename_pkg::phys_tag_t [rename_pkg::ARCH_REGS-1:0] rrat_map
);
    import rename_pkg::*;

    phys_tag_t [ARCH_REGS-1:0] map_q;
    logic                      wr_en;

    assign wr_en    = commit.valid && (commit.rd != '0);
    assign rrat_map = map_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < ARCH_REGS; i++) begin
                map_q[i] <= phys_tag_t'(i);  // Identity at boot.
            end
        end else if (wr_en) begin
            map_q[commit.rd] <= commit.pd;
        end
    end

    // ROB must retire a tag that exists and that the renamer handed out.
    a_commit_range: assert property (@(posedge clk) disable iff (rst)
        wr_en |-> commit.pd != '0 && int'(commit.pd) < PHYS_REGS);

    // pd_old must be the entry being replaced.
    a_commit_old: assert property (@(posedge clk) disable iff (rst)
        wr_en |-> commit.pd_old == map_q[commit.rd]);

endmodule

//--- rename_ctrl.sv
module rename_ctrl (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    req,
    input  rename_pkg::rename_req_t req_data,
    input  logic                    empty,
    input  rename_pkg::phys_tag_t   free_tag,
    input  rename_pkg::rename_rsp_t lookup,
    input  logic                    flush,
    output logic                    ack,
    output logic                    alloc,
    output logic                    rd_we,
    output rename_pkg::rename_rsp_t rsp
);
    import rename_pkg::*;

    typedef enum logic [1:0] {
        st_idle,
        st_grant,  // Waits here while no tag is free.
        st_acked,
        st_drain
    } state_t;

    state_t      state;
    state_t      state_next;
    logic        go;
    rename_rsp_t rsp_d;

    assign rd_we = (req_data.rd != '0) && !(req_data.opcode inside {op_br, op_store});
    assign go    = (state == st_grant) && (!rd_we || !empty);
    assign alloc = (state == st_grant) && rd_we && !empty;

    always_comb begin
        state_next = state;
        case (state)
            st_idle:  if (req) state_next = st_grant;
            st_grant: if (go) state_next = st_acked;
            st_acked: if (!req) state_next = st_drain;
            st_drain: state_next = st_idle;
            default:  state_next = st_idle;
        endcase
    end

    always_comb begin
        rsp_d        = lookup;
        rsp_d.pd     = rd_we ? free_tag : '0;
        rsp_d.pd_old = rd_we ? lookup.pd_old : '0;
        rsp_d.rd_we  = rd_we;
    end

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            state <= st_idle;
            ack   <= 1'b0;
        end else begin
            state <= state_next;
            ack   <= (state == st_acked);  // One cycle behind the state.
        end
    end

    always_ff @(posedge clk) begin
        if (go) begin
            rsp <= rsp_d;
        end
    end

    a_ack_needs_req: assert property (@(posedge clk) disable iff (rst) $rose(ack) |-> req);

endmodule

//--- rename_top.sv
module rename_top #(
    parameter int PHYS_REGS = 64,
    parameter int NUM_CDB   = 4
) (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           req,
    input  rename_pkg::rename_req_t        req_data,
    output logic                           ack,
    output rename_pkg::rename_rsp_t        rsp,
    input  rename_pkg::cdb_t [NUM_CDB-1:0] cdb,
    input  rename_pkg::commit_t            commit,
    input  logic                           flush
);
    import rename_pkg::*;

    logic                      alloc;
    logic                      empty;
    phys_tag_t                 free_tag;
    rename_rsp_t               lookup;
    phys_tag_t [ARCH_REGS-1:0] rrat_map;

    rename_ctrl i_rename_ctrl (
        .clk      (clk),
        .rst      (rst),
        .req      (req),
        .req_data (req_data),
        .empty    (empty),
        .free_tag (free_tag),
        .lookup   (lookup),
        .flush    (flush),
        .ack      (ack),
        .alloc    (alloc),
        .rd_we    (),  // Also carried in rsp.
        .rsp      (rsp)
    );

    rat #(.PHYS_REGS(PHYS_REGS), .NUM_CDB(NUM_CDB)) i_rat (
        .clk      (clk),
        .rst      (rst),
        .req_data (req_data),
        .alloc    (alloc),
        .pd       (free_tag),
        .cdb      (cdb),
        .flush    (flush),
        .rrat_map (rrat_map),
        .lookup   (lookup)
    );

    free_list #(.PHYS_REGS(PHYS_REGS)) i_free_list (
        .clk      (clk),
        .rst      (rst),
        .alloc    (alloc),
        .commit   (commit),
        .flush    (flush),
        .free_tag (free_tag),
        .empty    (empty)
    );

    rrat #(.PHYS_REGS(PHYS_REGS)) i_rrat (
        .clk      (clk),
        .rst      (rst),
        .commit   (commit),
        .rrat_map (rrat_map)
    );

endmodule

//--- tb_rename.sv
module tb_rename;
    import rename_pkg::*;

    localparam int PHYS_REGS      = 64;
    localparam int NUM_CDB        = 4;
    localparam int DEPTH          = PHYS_REGS - ARCH_REGS;
    localparam int MAX_HANDSHAKES = 250;  // About 90 used, with margin.
    localparam int WATCHDOG_T     = MAX_HANDSHAKES * 10 * 8;

    logic                 clk;
    logic                 rst;
    logic                 req;
    logic                 ack;
    logic                 flush;
    rename_req_t          req_data;
    rename_rsp_t          rsp;
    rename_rsp_t          exp_rsp;
    cdb_t [NUM_CDB-1:0]   cdb;
    commit_t              commit;

    // Reference model state.
    phys_tag_t m_map  [ARCH_REGS];
    phys_tag_t m_rrat [ARCH_REGS];
    logic      m_rdy  [ARCH_REGS];
    phys_tag_t m_fl   [DEPTH];
    int        m_head;
    int        m_tail;
    int        m_shadow;
    int        m_count;
    commit_t   in_flight [$];

    logic [31:0] rng = 32'h6bae9ff0;
    opcode_t     ops [9] = '{op_lui, op_auipc, op_jal, op_jalr, op_br,
                             op_load, op_store, op_imm, op_reg};
    string       test_name;
    int          err_count;
    int          check_count;
    int          test_count;
    int          err_at_start;
    bit          rsp_checked;

    rename_top #(.PHYS_REGS(PHYS_REGS), .NUM_CDB(NUM_CDB)) i_rename_top (
        .clk      (clk),
        .rst      (rst),
        .req      (req),
        .req_data (req_data),
        .ack      (ack),
        .rsp      (rsp),
        .cdb      (cdb),
        .commit   (commit),
        .flush    (flush)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    function automatic rename_req_t make_req(input opcode_t op, input int rd,
                                             input int rs1, input int rs2);
        return '{opcode: op, rd: arch_reg_t'(rd), rs1: arch_reg_t'(rs1), rs2: arch_reg_t'(rs2)};
    endfunction

    function automatic rename_req_t rand_req();
        rng = xorshift32(rng);
        return make_req(ops[rng % 9], rng[12:8], rng[17:13], rng[22:18]);
    endfunction

    // Expected response from the model state before this rename.
    function automatic rename_rsp_t ref_rename(input rename_req_t r);
        rename_rsp_t e;
        logic        use1;
        logic        use2;
        logic        we;
        use1 = 1'b1;
        use2 = 1'b1;
        case (r.opcode)
            op_lui, op_auipc, op_jal: begin
                use1 = 1'b0;
                use2 = 1'b0;
            end
            op_jalr, op_load, op_imm: use2 = 1'b0;
            default: ;
        endcase
        we          = (r.rd != 0) && (r.opcode != op_br) && (r.opcode != op_store);
        e           = '0;
        e.ps1       = use1 ? m_map[r.rs1] : '0;
        e.ps1_valid = use1 ? m_rdy[r.rs1] : 1'b1;
        e.ps2       = use2 ? m_map[r.rs2] : '0;
        e.ps2_valid = use2 ? m_rdy[r.rs2] : 1'b1;
        e.pd        = we ? m_fl[m_head] : '0;
        e.pd_old    = we ? m_map[r.rd] : '0;
        e.rd_we     = we;
        return e;
    endfunction

    always @(negedge clk) begin
        if (ack && !rsp_checked) begin
            rsp_checked = 1'b1;
            check_count++;
            if (rsp !== exp_rsp) begin
                $display("ERR %s: expected %h actual %h", test_name, exp_rsp, rsp);
                err_count++;
            end
        end
    end

    task automatic start_test(input string name);
        test_name    = name;
        err_at_start = err_count;
    endtask

    task automatic end_test();
        test_count++;
        $display("test %-13s %s", test_name, (err_count == err_at_start) ? "pass" : "fail");
    endtask

    task automatic commit_oldest();
        commit_t c;
        if (in_flight.size() == 0) begin
            $display("%s: commit requested with nothing in flight", test_name);
            err_count++;
            return;
        end
        c = in_flight.pop_front();
        @(posedge clk);
        commit <= c;
        @(posedge clk);
        commit <= '0;
        m_rrat[c.rd]  = c.pd;
        m_fl[m_tail]  = c.pd_old;
        m_tail        = (m_tail + 1) % DEPTH;
        m_shadow      = (m_shadow + 1) % DEPTH;
        m_count++;
    endtask

    // Stall mode holds req with an empty free list, then commits to release it.
    task automatic rename_op(input rename_req_t r, input bit stall);
        rsp_checked = 1'b0;
        exp_rsp     = ref_rename(r);
        @(posedge clk);
        req      <= 1'b1;
        req_data <= r;
        if (stall) begin
            repeat (8) begin
                @(posedge clk);
                if (ack) begin
                    $display("%s: ack rose while no physical tag was free", test_name);
                    err_count++;
                end
            end
            commit_oldest();
            exp_rsp = ref_rename(r);
        end
        @(posedge clk);
        while (!ack) @(posedge clk);
        req <= 1'b0;
        @(posedge clk);
        while (ack) @(posedge clk);
        if (!rsp_checked) begin
            $display("%s: response was never sampled while ack was high", test_name);
            err_count++;
        end
        if (exp_rsp.rd_we) begin
            m_map[r.rd] = exp_rsp.pd;
            m_rdy[r.rd] = 1'b0;
            m_head      = (m_head + 1) % DEPTH;
            m_count--;
            in_flight.push_back(commit_t'{valid: 1'b1, rd: r.rd,
                                          pd: exp_rsp.pd, pd_old: exp_rsp.pd_old});
        end
    endtask

    task automatic broadcast(input int bus, input phys_tag_t tag);
        @(posedge clk);
        cdb[bus] <= '{valid: 1'b1, pd: tag};
        @(posedge clk);
        cdb <= '0;
        for (int i = 0; i < ARCH_REGS; i++) begin
            if (m_map[i] == tag) m_rdy[i] = 1'b1;
        end
    endtask

    task automatic flush_all();
        @(posedge clk);
        flush <= 1'b1;
        @(posedge clk);
        flush <= 1'b0;
        for (int i = 0; i < ARCH_REGS; i++) begin
            m_map[i] = m_rrat[i];
            m_rdy[i] = 1'b1;
        end
        m_head  = m_shadow;
        m_count = DEPTH;
        in_flight.delete();
    endtask

    initial begin
        #(WATCHDOG_T);
        $display("run hung: the watchdog time limit was reached");
        $display("ERRORS FOUND");
        $finish;
    end

    initial begin
        rename_req_t r;
        rename_rsp_t e;
        phys_tag_t   old_tag;
        int          n;
        rst      = 1'b1;
        req      = 1'b0;
        flush    = 1'b0;
        req_data = '0;
        cdb      = '0;
        commit   = '0;
        for (int i = 0; i < ARCH_REGS; i++) begin
            m_map[i]  = phys_tag_t'(i);
            m_rrat[i] = phys_tag_t'(i);
            m_rdy[i]  = 1'b1;
        end
        for (int i = 0; i < DEPTH; i++) m_fl[i] = phys_tag_t'(ARCH_REGS + i);
        m_head   = 0;
        m_tail   = 0;
        m_shadow = 0;
        m_count  = DEPTH;
        repeat (5) @(posedge clk);
        rst <= 1'b0;

        start_test("reset_map");
        rename_op(make_req(op_reg, 0, 5, 7), 1'b0);
        rename_op(make_req(op_reg, 0, 31, 1), 1'b0);
        rename_op(make_req(op_lui, 0, 4, 9), 1'b0);
        rename_op(make_req(op_jal, 0, 6, 2), 1'b0);
        rename_op(make_req(op_imm, 0, 8, 3), 1'b0);
        rename_op(make_req(op_br, 3, 4, 6), 1'b0);
        end_test();

        start_test("rename_chain");
        rename_op(make_req(op_reg, 1, 1, 2), 1'b0);  // Source equals rd.
        rename_op(make_req(op_imm, 2, 1, 0), 1'b0);
        rename_op(make_req(op_reg, 1, 1, 2), 1'b0);
        rename_op(make_req(op_reg, 0, 1, 2), 1'b0);
        rename_op(make_req(op_lui, 5, 0, 0), 1'b0);
        rename_op(make_req(op_store, 6, 5, 1), 1'b0);
        end_test();

        start_test("writeback");
        rename_op(make_req(op_reg, 3, 1, 2), 1'b0);
        broadcast(2, m_map[3]);
        rename_op(make_req(op_reg, 0, 3, 3), 1'b0);
        rename_op(make_req(op_imm, 4, 0, 0), 1'b0);
        old_tag = m_map[4];
        rename_op(make_req(op_imm, 4, 0, 0), 1'b0);
        broadcast(0, old_tag);  // Stale tag, entry stays busy.
        rename_op(make_req(op_reg, 0, 4, 3), 1'b0);
        end_test();

        start_test("back_pressure");
        n = 0;
        while (m_count > 0) begin
            rename_op(make_req(op_reg, 1 + n % 31, n % 32, (n + 7) % 32), 1'b0);
            n++;
        end
        rename_op(make_req(op_reg, 7, 1, 2), 1'b1);
        end_test();

        start_test("flush");
        repeat (12) commit_oldest();
        repeat (20) begin
            r = rand_req();
            e = ref_rename(r);
            if (e.rd_we && m_count == 0) commit_oldest();
            rename_op(r, 1'b0);
            rng = xorshift32(rng);
            if (rng[1:0] == 2'b00 && in_flight.size() > 0) commit_oldest();
        end
        repeat (5) commit_oldest();
        flush_all();
        for (int i = 0; i < ARCH_REGS; i += 2) begin
            rename_op(make_req(op_reg, 0, i, i + 1), 1'b0);
        end
        rename_op(make_req(op_imm, 9, 9, 0), 1'b0);
        end_test();

        $display("tests=%0d checks=%0d errors=%0d", test_count, check_count, err_count);
        if (err_count == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

//--- rename.f
rename_pkg.sv
rat.sv
free_list.sv
rrat.sv
rename_ctrl.sv
rename_top.sv
tb_rename.sv

//--- Bender.yml
package:
  name: rename

sources:
  - rename_pkg.sv
  - rat.sv
  - free_list.sv
  - rrat.sv
  - rename_ctrl.sv
  - rename_top.sv
  - target: test
    files:
      - tb_rename.sv
